// File: fetchPkg.sv
// Widths, opcode and state enums, instruction field layout and fetch stage structs.
package fetchPkg;

   localparam int PC_W = 16;
   localparam int INSTR_W = 16;

   // Instruction field widths.
   localparam int OPCODE_W = 5;
   localparam int REG_IDX_W = 3;
   localparam int REST_W = INSTR_W - OPCODE_W - 2 * REG_IDX_W;

   typedef logic [REG_IDX_W-1:0] regIdxT;

   // Opcode lives in bits 15..11.
   typedef enum logic [OPCODE_W-1:0] {
      HALT = 5'b00000,
      NOP  = 5'b00001,
      ADDI = 5'b01000,
      BEQZ = 5'b01100,
      LI   = 5'b11000,
      ADD  = 5'b11011
   } opcodeT;

   // Rs in 10..8, rt in 7..5, then immediate or destination bits.
   typedef struct packed {
      opcodeT opcode;
      regIdxT rs;
      regIdxT rt;
      logic [REST_W-1:0] rest;
   } instrT;

   // Pending write of one later pipeline stage.
   typedef struct packed {
      logic regWrt;
      regIdxT wrtReg;
      logic branch;
   } stageWriteT;

   typedef struct packed {
      stageWriteT d;
      stageWriteT x;
      stageWriteT m;
      stageWriteT w;
   } pipeWritesT;

   typedef struct packed {
      logic valid;
      instrT instruction;
      logic [PC_W-1:0] incPc;
   } fetchOutT;

   typedef enum logic [1:0] {IDLE, RUN, BRANCH_WAIT, HALTED} fetchStateT;

endpackage

// File: pcCounter.sv
// Program counter register with +2 increment, load, clear and sticky wrap error.
`timescale 1ns/100ps

module pcCounter (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       clear,
   input  logic                       advance,
   input  logic                       loadPc,
   input  logic [fetchPkg::PC_W-1:0]  targetPc,
   output logic [fetchPkg::PC_W-1:0]  pc,
   output logic [fetchPkg::PC_W-1:0]  incPc,
   output logic                       err
);

   import fetchPkg::*;

   logic [PC_W:0] sum;
   logic carry;

   // Extra bit catches the wrap from 0xFFFE to 0.
   assign sum = {1'b0, pc} + (PC_W + 1)'(2);
   assign incPc = sum[PC_W-1:0];
   assign carry = sum[PC_W];

   always_ff @(posedge clk) begin
      if (rst || clear) begin
         pc <= '0;
         err <= 1'b0;
      end else if (loadPc) begin
         // Redirect wins over a plain step.
         pc <= targetPc;
      end else if (advance) begin
         pc <= incPc;
         err <= err | carry;
      end
   end

endmodule

// File: instrMem.sv
// Word-organized instruction memory, asynchronous read and synchronous load port.
`timescale 1ns/100ps

module instrMem #(
   parameter int MEM_WORDS = 256
) (
   input  logic                       clk,
   input  logic                       load,
   input  logic [fetchPkg::PC_W-1:0]  loadAddr,
   input  fetchPkg::instrT            loadData,
   input  logic [fetchPkg::PC_W-1:0]  addr,
   output fetchPkg::instrT            instruction
);

   import fetchPkg::*;

   localparam int ADDR_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

   logic [INSTR_W-1:0] mem [MEM_WORDS];

   logic [PC_W-2:0] rdWord;
   logic [PC_W-2:0] wrWord;
   logic [ADDR_W-1:0] rdIdx;
   logic [ADDR_W-1:0] wrIdx;

   // Byte addresses, so drop bit 0 and fold into the array depth.
   assign rdWord = addr[PC_W-1:1];
   assign wrWord = loadAddr[PC_W-1:1];
   assign rdIdx = ADDR_W'(rdWord % MEM_WORDS);
   assign wrIdx = ADDR_W'(wrWord % MEM_WORDS);

   assign instruction = instrT'(mem[rdIdx]);

   // Load strobe is already qualified by the controller.
   always_ff @(posedge clk) begin
      if (load) begin
         mem[wrIdx] <= loadData;
      end
   end

endmodule

// File: hazardDetect.sv
// Opcode decoder and register hazard check against later stage writes and branches.
`timescale 1ns/100ps

module hazardDetect (
   input  fetchPkg::instrT       instruction,
   input  fetchPkg::pipeWritesT  pipeWrites,
   output logic                  stall,
   output logic                  isBranch,
   output logic                  isHalt
);

   import fetchPkg::*;

   localparam int NUM_STAGES = 4;

   logic readsRs;
   logic readsRt;
   logic rsHit;
   logic rtHit;
   logic branchInFlight;

   stageWriteT stages [NUM_STAGES];

   // True when this stage will write register r.
   function automatic logic writesReg(stageWriteT s, regIdxT r);
      return s.regWrt && (s.wrtReg == r);
   endfunction

   // Decode, execute, memory and writeback in order.
   assign stages[0] = pipeWrites.d;
   assign stages[1] = pipeWrites.x;
   assign stages[2] = pipeWrites.m;
   assign stages[3] = pipeWrites.w;

   // Register reads and class of the fetched word.
   always_comb begin
      readsRs = 1'b0;
      readsRt = 1'b0;
      isBranch = 1'b0;
      isHalt = 1'b0;
      case (instruction.opcode)
         HALT: begin
            isHalt = 1'b1;
         end
         ADDI: begin
            readsRs = 1'b1;
         end
         ADD: begin
            readsRs = 1'b1;
            readsRt = 1'b1;
         end
         BEQZ: begin
            readsRs = 1'b1;
            isBranch = 1'b1;
         end
         NOP, LI: begin
            readsRs = 1'b0;
         end
         // Unused codes behave as NOP.
         default: begin
            readsRs = 1'b0;
         end
      endcase
   end

   // Scan all later stages.
   always_comb begin
      rsHit = 1'b0;
      rtHit = 1'b0;
      branchInFlight = 1'b0;
      for (int i = 0; i < NUM_STAGES; i++) begin
         rsHit = rsHit | writesReg(stages[i], instruction.rs);
         rtHit = rtHit | writesReg(stages[i], instruction.rt);
         branchInFlight = branchInFlight | stages[i].branch;
      end
   end

   // Any unresolved branch downstream also holds fetch.
   assign stall = (readsRs && rsHit) || (readsRt && rtHit) || branchInFlight;

endmodule

// File: fetchCtrl.sv
// Fetch FSM for idle, run, branch wait and halt, with PC and issue controls.
`timescale 1ns/100ps

module fetchCtrl (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  start,
   input  logic                  redirect,
   input  logic                  stall,
   input  logic                  isBranch,
   input  logic                  isHalt,
   output logic                  issue,
   output logic                  advance,
   output logic                  loadPc,
   output logic                  clear,
   output logic                  memWriteOk,
   output logic                  halted,
   output fetchPkg::fetchStateT  state
);

   import fetchPkg::*;

   fetchStateT nextState;

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= IDLE;
      end else begin
         state <= nextState;
      end
   end

   always_comb begin
      nextState = state;
      case (state)
         IDLE: begin
            if (start) nextState = RUN;
         end
         RUN: begin
            if (issue && isBranch) begin
               nextState = BRANCH_WAIT;
            end else if (issue && isHalt) begin
               nextState = HALTED;
            end
         end
         // Variable latency until the target comes back.
         BRANCH_WAIT: begin
            if (redirect) nextState = RUN;
         end
         HALTED: begin
            if (start) nextState = RUN;
         end
         default: nextState = IDLE;
      endcase
   end

   // One issue slot per cycle in RUN unless stalled.
   assign issue = (state == RUN) && !stall;
   // Halt keeps the PC where it is.
   assign advance = issue && !isHalt;
   assign loadPc = (state == BRANCH_WAIT) && redirect;

   assign memWriteOk = (state == IDLE) || (state == HALTED);
   assign clear = start && memWriteOk;
   assign halted = (state == HALTED);

endmodule

// File: fetchStage.sv
// Fetch stage top level joining PC counter, instruction memory, hazard check and FSM.
`timescale 1ns/100ps

module fetchStage #(
   parameter int MEM_WORDS = 256
) (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       start,
   input  logic                       load,
   input  logic [fetchPkg::PC_W-1:0]  loadAddr,
   input  fetchPkg::instrT            loadData,
   input  fetchPkg::pipeWritesT       pipeWrites,
   input  logic                       redirect,
   input  logic [fetchPkg::PC_W-1:0]  targetPc,
   output fetchPkg::fetchOutT         fetchOut,
   output logic                       halted,
   output logic                       err
);

   import fetchPkg::*;

   logic [PC_W-1:0] pc;
   logic [PC_W-1:0] incPc;
   instrT instruction;
   logic stall;
   logic isBranch;
   logic isHalt;
   logic issue;
   logic advance;
   logic loadPc;
   logic clear;
   logic memWriteOk;
   logic memLoad;

   // Loads only land while idle or halted.
   assign memLoad = load && memWriteOk;

   pcCounter pcCounter_i (
      .clk(clk), .rst(rst), .clear(clear), .advance(advance), .loadPc(loadPc),
      .targetPc(targetPc), .pc(pc), .incPc(incPc), .err(err)
   );

   instrMem #(.MEM_WORDS(MEM_WORDS)) instrMem_i (
      .clk(clk), .load(memLoad), .loadAddr(loadAddr), .loadData(loadData),
      .addr(pc), .instruction(instruction)
   );

   hazardDetect hazardDetect_i (
      .instruction(instruction), .pipeWrites(pipeWrites),
      .stall(stall), .isBranch(isBranch), .isHalt(isHalt)
   );

   // State port is watched by the bound checks only.
   fetchCtrl fetchCtrl_i (
      .clk(clk), .rst(rst), .start(start), .redirect(redirect), .stall(stall),
      .isBranch(isBranch), .isHalt(isHalt), .issue(issue), .advance(advance),
      .loadPc(loadPc), .clear(clear), .memWriteOk(memWriteOk), .halted(halted),
      .state()
   );

   assign fetchOut.valid = issue;
   assign fetchOut.instruction = instruction;
   assign fetchOut.incPc = incPc;

endmodule

// File: fetchAssertions.sv
// Concurrent checks on fetch FSM issue, halt and redirect controls and the sticky PC error.
`timescale 1ns/100ps

module fetchAssertions (
   input logic                  clk,
   input logic                  rst,
   input logic                  clear,
   input logic                  issue,
   input logic                  loadPc,
   input logic                  halted,
   input logic                  err,
   input fetchPkg::fetchStateT  state
);

   import fetchPkg::*;

   // Failed check count.
   int failCount = 0;

   issueOnlyInRun: assert property (@(posedge clk) disable iff (rst) issue |-> state == RUN)
      else begin
         failCount++;
         $error("issue raised outside RUN");
      end

   haltedMatchesState: assert property (@(posedge clk) disable iff (rst)
      halted == (state == HALTED))
      else begin
         failCount++;
         $error("halted does not follow the HALTED state");
      end

   loadPcOnlyInWait: assert property (@(posedge clk) disable iff (rst)
      loadPc |-> state == BRANCH_WAIT)
      else begin
         failCount++;
         $error("loadPc raised outside BRANCH_WAIT");
      end

   // Sticky until reset or an accepted start.
   errSticky: assert property (@(posedge clk) disable iff (rst)
      $fell(err) |-> ($past(rst) || $past(clear)))
      else begin
         failCount++;
         $error("err dropped without rst or clear");
      end

endmodule

// File: tbFetch.sv
// Fetch stage testbench with clock, reset, stimulus, reference model, compare tasks and watchdog.
`timescale 1ns/100ps

module tbFetch;

   import fetchPkg::*;

   localparam int CLK_PERIOD = 40;
   localparam int RESET_CYCLES = 16;
   localparam int MEM_WORDS = 256;
   localparam int PROG_LEN = 48;
   localparam int HALT_ADDR = 2 * (PROG_LEN - 1);
   // Two cycles per loaded word, then four runs at up to eight cycles a word.
   localparam int PROG_CYCLES = 2 * MEM_WORDS + 4 * 8 * PROG_LEN;
   localparam int TIMEOUT_NS = CLK_PERIOD * (RESET_CYCLES + PROG_CYCLES + 400);

   logic clk;
   logic rst;
   logic start;
   logic load;
   logic [PC_W-1:0] loadAddr;
   instrT loadData;
   pipeWritesT pipeWrites;
   logic redirect;
   logic [PC_W-1:0] targetPc;
   fetchOutT fetchOut;
   logic halted;
   logic err;

   // Reference model state.
   fetchStateT mState;
   logic [PC_W-1:0] mPc;
   logic mErr;
   instrT modelMem [MEM_WORDS];
   int stallCount = 0;
   int branchCount = 0;
   logic wrapSeen = 1'b0;
   logic [31:0] lcgState = 32'd65165;

   fetchStage #(.MEM_WORDS(MEM_WORDS)) dut_i (
      .clk(clk), .rst(rst), .start(start), .load(load), .loadAddr(loadAddr),
      .loadData(loadData), .pipeWrites(pipeWrites), .redirect(redirect),
      .targetPc(targetPc), .fetchOut(fetchOut), .halted(halted), .err(err)
   );

   bind fetchCtrl fetchAssertions ctrlChecks_i (
      .clk(clk), .rst(rst), .clear(clear), .issue(issue), .loadPc(loadPc),
      .halted(halted), .err(1'b0), .state(state)
   );

   // The counter copy only watches the sticky error.
   bind pcCounter fetchAssertions pcChecks_i (
      .clk(clk), .rst(rst), .clear(clear), .issue(1'b0), .loadPc(1'b0),
      .halted(1'b0), .err(err), .state(fetchPkg::IDLE)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic stopWithFailure(input string why);
      $display("%s", why);
      $display("Result: FAILED");
      $fatal(1);
   endtask

   // Bound assertion failures seen so far.
   function automatic int boundFailures();
      return dut_i.fetchCtrl_i.ctrlChecks_i.failCount
         + dut_i.pcCounter_i.pcChecks_i.failCount;
   endfunction

   function automatic logic [31:0] nextRand();
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;
      // Low bits of the LCG repeat quickly.
      return {16'd0, lcgState[31:16]};
   endfunction

   // Mostly ADD, ADDI and LI, one BEQZ in sixteen.
   function automatic instrT randomWord();
      instrT w;
      logic [31:0] r;
      r = nextRand();
      if (r[3:0] == 4'd0) w.opcode = BEQZ;
      else if (r[3:0] < 4'd6) w.opcode = ADD;
      else if (r[3:0] < 4'd11) w.opcode = ADDI;
      else w.opcode = LI;
      w.rs = r[6:4];
      w.rt = r[9:7];
      w.rest = r[14:10];
      return w;
   endfunction

   function automatic stageWriteT randomStage();
      stageWriteT s;
      logic [31:0] r;
      r = nextRand();
      s.regWrt = (r[1:0] == 2'd0);
      s.wrtReg = r[4:2];
      s.branch = (r[9:5] == 5'd0);
      return s;
   endfunction

   function automatic pipeWritesT randomPipes();
      pipeWritesT p;
      p.d = randomStage();
      p.x = randomStage();
      p.m = randomStage();
      p.w = randomStage();
      return p;
   endfunction

   function automatic int wordIndex(logic [PC_W-1:0] a);
      return int'(a[PC_W-1:1]) % MEM_WORDS;
   endfunction

   // Register read hazard or unresolved branch in any later stage.
   function automatic logic hazardFor(instrT ins, pipeWritesT pw);
      stageWriteT st [4];
      logic useRs;
      logic useRt;
      logic hit;
      st[0] = pw.d;
      st[1] = pw.x;
      st[2] = pw.m;
      st[3] = pw.w;
      useRs = (ins.opcode == ADDI) || (ins.opcode == ADD) || (ins.opcode == BEQZ);
      useRt = (ins.opcode == ADD);
      hit = 1'b0;
      for (int i = 0; i < 4; i++) begin
         if (st[i].branch) hit = 1'b1;
         if (st[i].regWrt && useRs && (st[i].wrtReg == ins.rs)) hit = 1'b1;
         if (st[i].regWrt && useRt && (st[i].wrtReg == ins.rt)) hit = 1'b1;
      end
      return hit;
   endfunction

   function automatic fetchOutT expectedOut();
      fetchOutT e;
      e.instruction = modelMem[wordIndex(mPc)];
      e.incPc = mPc + PC_W'(2);
      e.valid = (mState == RUN) && !hazardFor(e.instruction, pipeWrites);
      return e;
   endfunction

   task automatic compareFetch(input fetchOutT expOut, input fetchOutT act);
      if (act.valid !== expOut.valid) begin
         stopWithFailure($sformatf("mismatch at %0t ns: valid expected %0b got %0b",
            $time, expOut.valid, act.valid));
      end else if (expOut.valid && (act !== expOut)) begin
         stopWithFailure($sformatf("mismatch at %0t ns: fetchOut expected %h got %h",
            $time, expOut, act));
      end
   endtask

   task automatic compareFlag(input logic expFlag, input logic act, input string name);
      if (act !== expFlag) begin
         stopWithFailure($sformatf("mismatch at %0t ns: %s expected %0b got %0b",
            $time, name, expFlag, act));
      end
   endtask

   // Compare against the model, then step it.
   always @(posedge clk) begin
      fetchOutT expOut;
      logic [PC_W:0] sum;
      if (boundFailures() > 0) begin
         stopWithFailure("a bound assertion on the controller or PC counter failed");
      end
      if (rst) begin
         mState = IDLE;
         mPc = '0;
         mErr = 1'b0;
      end else begin
         expOut = expectedOut();
         compareFetch(expOut, fetchOut);
         compareFlag(mState == HALTED, halted, "halted");
         compareFlag(mErr, err, "err");
         if (load && (mState == IDLE || mState == HALTED)) begin
            modelMem[wordIndex(loadAddr)] = loadData;
         end
         sum = {1'b0, mPc} + (PC_W + 1)'(2);
         case (mState)
            IDLE, HALTED: begin
               if (start) begin
                  mState = RUN;
                  mPc = '0;
                  mErr = 1'b0;
               end
            end
            RUN: begin
               if (!expOut.valid) begin
                  stallCount++;
               end else if (expOut.instruction.opcode == HALT) begin
                  mState = HALTED;
               end else begin
                  mPc = sum[PC_W-1:0];
                  mErr = mErr | sum[PC_W];
                  wrapSeen = wrapSeen | sum[PC_W];
                  if (expOut.instruction.opcode == BEQZ) begin
                     mState = BRANCH_WAIT;
                     branchCount++;
                  end
               end
            end
            BRANCH_WAIT: begin
               if (redirect) begin
                  mState = RUN;
                  mPc = targetPc;
               end
            end
            default: mState = IDLE;
         endcase
      end
   end

   task automatic writeWord(input logic [PC_W-1:0] addr, input instrT data);
      @(negedge clk);
      load = 1'b1;
      loadAddr = addr;
      loadData = data;
      @(negedge clk);
      load = 1'b0;
   endtask

   task automatic pulseStart();
      @(negedge clk);
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
   endtask

   // Drives one run until HALTED, answering each branch after a random wait.
   task automatic runToHalt(input logic noisy, input logic wrapFirst);
      int waitLeft;
      logic wrapPending;
      logic [PC_W-1:0] target;
      waitLeft = -1;
      wrapPending = wrapFirst;
      forever begin
         @(negedge clk);
         redirect = 1'b0;
         load = 1'b0;
         if (mState == HALTED) break;
         pipeWrites = noisy ? randomPipes() : '0;
         if (mState == BRANCH_WAIT) begin
            if (waitLeft < 0) waitLeft = int'(nextRand() % 8);
            if (waitLeft == 0) begin
               // Forward targets only, so the run reaches HALT.
               target = mPc + PC_W'(2 * (nextRand() % 4));
               if (target > HALT_ADDR) target = PC_W'(HALT_ADDR);
               redirect = 1'b1;
               targetPc = wrapPending ? 16'hFFFE : target;
               wrapPending = 1'b0;
               waitLeft = -1;
            end else begin
               waitLeft--;
            end
         end else if (nextRand() % 8 == 0) begin
            redirect = 1'b1;
            targetPc = PC_W'(nextRand());
         end else if (nextRand() % 16 == 0) begin
            load = 1'b1;
            loadAddr = '0;
            loadData = randomWord();
         end
      end
      pipeWrites = '0;
   endtask

   initial begin
      #(TIMEOUT_NS);
      stopWithFailure("watchdog: simulation did not finish");
   end

   initial begin
      instrT w;
      rst = 1'b1;
      start = 1'b0;
      load = 1'b0;
      loadAddr = '0;
      loadData = '0;
      pipeWrites = '0;
      redirect = 1'b0;
      targetPc = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      // Random program, HALT at its end, address-tagged LI words above it.
      for (int i = 0; i < MEM_WORDS; i++) begin
         w = '0;
         if (i < PROG_LEN - 1) begin
            w = randomWord();
         end else if (i == PROG_LEN - 1) begin
            w.opcode = HALT;
         end else begin
            w.opcode = LI;
            {w.rs, w.rt, w.rest} = 11'(i);
         end
         writeWord(PC_W'(2 * i), w);
      end
      // In-order run, no pending writes.
      pulseStart();
      runToHalt(1'b0, 1'b0);
      // Reload one word while halted, restart with random stage writes.
      writeWord(PC_W'(2), randomWord());
      pulseStart();
      runToHalt(1'b1, 1'b0);
      // Branch at 0 redirected to the top word, so the next step wraps.
      w = '0;
      w.opcode = BEQZ;
      w.rs = 3'd1;
      writeWord('0, w);
      pulseStart();
      runToHalt(1'b0, 1'b1);
      // Start clears the sticky error.
      pulseStart();
      runToHalt(1'b0, 1'b0);
      if (boundFailures() > 0) begin
         stopWithFailure("a bound assertion on the controller or PC counter failed");
      end else if (stallCount == 0 || branchCount == 0 || !wrapSeen) begin
         stopWithFailure("test did not exercise stalls, branches and the PC wrap");
      end else begin
         $display("Result: PASSED");
         $finish;
      end
   end

endmodule

// File: vlog.f
fetchPkg.sv
pcCounter.sv
instrMem.sv
hazardDetect.sv
fetchCtrl.sv
fetchStage.sv
fetchAssertions.sv
tbFetch.sv
